// File: source/glbCfgPkg.sv
// Global buffer configuration package with port counts, the bank map entry and control states
`default_nettype none

package glbCfgPkg;

    // ====================
    // Sizes
    // ====================

    // Banks shared by all ports
    localparam int numBank = 4;
    // Write ports into the buffer
    localparam int numWrPort = 2;
    // Read ports out of the buffer
    localparam int numRdPort = 2;

    // ====================
    // Index types
    // ====================

    // Absolute bank number or relative index in a port's bank list
    typedef logic [1:0] bankIdxT;
    typedef logic [0:0] wrPortIdxT;
    typedef logic [0:0] rdPortIdxT;

    // One bank map entry, written during configuration
    typedef struct packed {
        logic      used;
        wrPortIdxT wrPort;
        rdPortIdxT rdPort;
        bankIdxT   relIdx;
    } bankMapT;

    // Whole map, one entry per bank
    typedef bankMapT [numBank-1:0] bankMapArrT;

    // Control phases
    typedef enum logic [1:0] {stIdle, stCfg, stRun} glbStateT;

endpackage

`default_nettype wire

// File: source/glbDataPkg.sv
// Global buffer data package with word and address widths, request structs and address split
`default_nettype none

package glbDataPkg;

    // Data word
    localparam int wordW = 32;
    typedef logic [wordW-1:0] wordT;

    // Bank geometry
    localparam int bankDepth = 64;
    localparam int wordAddrW = $clog2(bankDepth);
    localparam int relIdxW = 2;
    // Port address holds the relative bank in upper bits and the word in lower bits
    localparam int portAddrW = relIdxW + wordAddrW;

    typedef logic [wordAddrW-1:0] wordAddrT;
    typedef logic [portAddrW-1:0] portAddrT;

    // Write port request
    typedef struct packed {
        portAddrT addr;
        wordT     data;
    } wrReqT;

    // One bank access per cycle
    typedef struct packed {
        logic     en;
        logic     we;
        wordAddrT addr;
        wordT     data;
    } bankCmdT;

    // Relative bank field of a port address
    function automatic logic [relIdxW-1:0] relIdxOf(portAddrT addr);
        return addr[portAddrW-1:wordAddrW];
    endfunction

    // Word field of a port address
    function automatic wordAddrT wordAddrOf(portAddrT addr);
        return addr[wordAddrW-1:0];
    endfunction

endpackage

`default_nettype wire

// File: source/glbBankRam.sv
// Single-port synchronous SRAM bank taking one write or one read per cycle
`timescale 1ns/1ns
`default_nettype none

module glbBankRam (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire glbDataPkg::bankCmdT cmd,
    output glbDataPkg::wordT         rdData
);

    // ====================
    // Storage
    // ====================

    glbDataPkg::wordT mem [glbDataPkg::bankDepth];

    // Write when we set and read otherwise
    // rdData keeps the last read word on idle cycles
    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.we) begin
                mem[cmd.addr] <= cmd.data;
            end else begin
                rdData <= mem[cmd.addr];
            end
        end
    end

    // ====================
    // Checks
    // ====================

    // Routed word address must be a known index on every enabled access
    bankAddrKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        cmd.en |-> !$isunknown({cmd.we, cmd.addr})
    );

endmodule

`default_nettype wire

// File: source/glbBankCtrl.sv
// Buffer control FSM with idle, configure and run phases, bank map storage and status pulses
`timescale 1ns/1ns
`default_nettype none

module glbBankCtrl (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  cfgStart,
    input  wire logic                  cfgVld,
    input  wire glbCfgPkg::bankIdxT    cfgBank,
    input  wire glbCfgPkg::bankMapT    cfgEntry,
    input  wire logic                  runStart,
    input  wire logic                  runStop,
    input  wire logic                  clearBanks,
    output logic                       running,
    output logic                       bankFinish,
    output logic                       bankClr,
    output glbCfgPkg::bankMapArrT      bankMap
);

    glbCfgPkg::glbStateT state;

    // ====================
    // State machine
    // ====================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= glbCfgPkg::stIdle;
            bankMap    <= '0;
            bankFinish <= 1'b0;
            bankClr    <= 1'b0;
        end else begin
            // Pulses last one cycle
            bankFinish <= 1'b0;
            bankClr    <= 1'b0;
            case (state)
                glbCfgPkg::stIdle: begin
                    // Map clear only while idle
                    if (clearBanks) begin
                        bankMap <= '0;
                        bankClr <= 1'b1;
                    end
                    if (cfgStart) begin
                        state <= glbCfgPkg::stCfg;
                    end
                end
                glbCfgPkg::stCfg: begin
                    if (cfgVld) begin
                        bankMap[cfgBank] <= cfgEntry;
                    end
                    if (runStart) begin
                        state <= glbCfgPkg::stRun;
                    end
                end
                glbCfgPkg::stRun: begin
                    if (runStop) begin
                        state      <= glbCfgPkg::stIdle;
                        bankFinish <= 1'b1;
                    end
                end
                default: state <= glbCfgPkg::stIdle;
            endcase
        end
    end

    // Run level straight from the state register
    assign running = (state == glbCfgPkg::stRun);

    // ====================
    // Map consistency
    // ====================

    // Two used banks of one port with the same relative index
    function automatic logic relClash(glbCfgPkg::bankMapArrT m, logic useRd);
        logic clash;
        logic samePort;
        clash = 1'b0;
        for (int a = 0; a < glbCfgPkg::numBank; a++) begin
            for (int b = a + 1; b < glbCfgPkg::numBank; b++) begin
                samePort = useRd ? (m[a].rdPort == m[b].rdPort) : (m[a].wrPort == m[b].wrPort);
                if (m[a].used && m[b].used && samePort && (m[a].relIdx == m[b].relIdx)) begin
                    clash = 1'b1;
                end
            end
        end
        return clash;
    endfunction

    // Routes would hit two banks with one address
    wrRelIdxUnique: assert property (
        @(posedge clk) disable iff (!rstN)
        running |-> !relClash(bankMap, 1'b0)
    );

    rdRelIdxUnique: assert property (
        @(posedge clk) disable iff (!rstN)
        running |-> !relClash(bankMap, 1'b1)
    );

endmodule

`default_nettype wire

// File: source/glbRdRoute.sv
// Read router that steers port requests to owning banks and returns bank data per port
`timescale 1ns/1ns
`default_nettype none

module glbRdRoute (
    input  wire logic                                                   clk,
    input  wire logic                                                   rstN,
    input  wire logic                                                   running,
    input  wire glbCfgPkg::bankMapArrT                                  bankMap,
    input  wire logic [glbCfgPkg::numRdPort-1:0]                        rdReqVld,
    input  wire glbDataPkg::portAddrT [glbCfgPkg::numRdPort-1:0]        rdReqAddr,
    input  wire logic [glbCfgPkg::numRdPort-1:0]                        rdDatRdy,
    input  wire glbDataPkg::wordT [glbCfgPkg::numBank-1:0]              bankRdData,
    output logic [glbCfgPkg::numRdPort-1:0]                             rdReqRdy,
    output logic [glbCfgPkg::numRdPort-1:0]                             rdDatVld,
    output glbDataPkg::wordT [glbCfgPkg::numRdPort-1:0]                 rdDat,
    output glbDataPkg::bankCmdT [glbCfgPkg::numBank-1:0]                bankRdCmd,
    output logic [glbCfgPkg::numBank-1:0]                               bankRdBusy
);

    logic [glbCfgPkg::numRdPort-1:0]                rdAcc;
    logic [glbCfgPkg::numRdPort-1:0]                portHit;
    glbCfgPkg::bankIdxT [glbCfgPkg::numRdPort-1:0]  portBank;
    logic [glbCfgPkg::numRdPort-1:0]                retHit;
    glbCfgPkg::bankIdxT [glbCfgPkg::numRdPort-1:0]  retBank;

    // Accept when running and return slot empty or draining
    assign rdReqRdy = {glbCfgPkg::numRdPort{running}} & (~rdDatVld | rdDatRdy);
    assign rdAcc    = rdReqVld & rdReqRdy;

    // ====================
    // Bank side
    // ====================

    always_comb begin
        glbCfgPkg::rdPortIdxT owner;
        for (int b = 0; b < glbCfgPkg::numBank; b++) begin
            owner = bankMap[b].rdPort;
            // Owner request whose relative bank matches this entry
            bankRdBusy[b] = bankMap[b].used && rdAcc[owner]
                && (glbDataPkg::relIdxOf(rdReqAddr[owner]) == bankMap[b].relIdx);
            bankRdCmd[b].en   = bankRdBusy[b];
            bankRdCmd[b].we   = 1'b0;
            bankRdCmd[b].addr = glbDataPkg::wordAddrOf(rdReqAddr[owner]);
            bankRdCmd[b].data = '0;
        end
    end

    // Which bank, if any, serves each port this cycle
    always_comb begin
        for (int p = 0; p < glbCfgPkg::numRdPort; p++) begin
            portHit[p]  = 1'b0;
            portBank[p] = '0;
            for (int b = 0; b < glbCfgPkg::numBank; b++) begin
                if (bankRdBusy[b] && (bankMap[b].rdPort == glbCfgPkg::rdPortIdxT'(p))) begin
                    portHit[p]  = 1'b1;
                    portBank[p] = glbCfgPkg::bankIdxT'(b);
                end
            end
        end
    end

    // ====================
    // Return side
    // ====================

    // Valid set on accept and cleared when taken
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdDatVld <= '0;
        end else begin
            rdDatVld <= rdAcc | (rdDatVld & ~rdDatRdy);
        end
    end

    // Source of the pending word
    always_ff @(posedge clk) begin
        for (int p = 0; p < glbCfgPkg::numRdPort; p++) begin
            if (rdAcc[p]) begin
                retHit[p]  <= portHit[p];
                retBank[p] <= portBank[p];
            end
        end
    end

    // Bank output holds while stalled since only the owner port reads it
    // Miss on unmapped relative bank returns zero
    always_comb begin
        for (int p = 0; p < glbCfgPkg::numRdPort; p++) begin
            rdDat[p] = retHit[p] ? bankRdData[retBank[p]] : '0;
        end
    end

    // Data held under back-pressure by the bank output register
    for (genvar p = 0; p < glbCfgPkg::numRdPort; p++) begin : genRdChk
        rdDatStable: assert property (
            @(posedge clk) disable iff (!rstN)
            (rdDatVld[p] && !rdDatRdy[p]) |=> $stable(rdDat[p])
        );
    end

endmodule

`default_nettype wire

// File: source/glbWrRoute.sv
// Write router that merges reads and port writes into bank commands with reads winning a clash
`timescale 1ns/1ns
`default_nettype none

module glbWrRoute (
    input  wire logic                                               running,
    input  wire glbCfgPkg::bankMapArrT                              bankMap,
    input  wire logic [glbCfgPkg::numWrPort-1:0]                    wrVld,
    input  wire glbDataPkg::wrReqT [glbCfgPkg::numWrPort-1:0]       wrReq,
    input  wire glbDataPkg::bankCmdT [glbCfgPkg::numBank-1:0]       bankRdCmd,
    input  wire logic [glbCfgPkg::numBank-1:0]                      bankRdBusy,
    output logic [glbCfgPkg::numWrPort-1:0]                         wrRdy,
    output glbDataPkg::bankCmdT [glbCfgPkg::numBank-1:0]            bankCmd
);

    // ====================
    // Bank commands
    // ====================

    always_comb begin
        glbCfgPkg::wrPortIdxT owner;
        glbDataPkg::wrReqT    req;
        for (int b = 0; b < glbCfgPkg::numBank; b++) begin
            owner = bankMap[b].wrPort;
            req   = wrReq[owner];
            if (bankRdBusy[b]) begin
                // Read has the bank this cycle
                bankCmd[b] = bankRdCmd[b];
            end else begin
                bankCmd[b].en   = running && bankMap[b].used && wrVld[owner]
                    && (glbDataPkg::relIdxOf(req.addr) == bankMap[b].relIdx);
                bankCmd[b].we   = 1'b1;
                bankCmd[b].addr = glbDataPkg::wordAddrOf(req.addr);
                bankCmd[b].data = req.data;
            end
        end
    end

    // ====================
    // Write ready
    // ====================

    // Held off only by a read on the mapped target bank
    // Unmapped target stays ready and the write is dropped
    always_comb begin
        logic blocked;
        for (int p = 0; p < glbCfgPkg::numWrPort; p++) begin
            blocked = 1'b0;
            for (int b = 0; b < glbCfgPkg::numBank; b++) begin
                if (bankMap[b].used && (bankMap[b].wrPort == glbCfgPkg::wrPortIdxT'(p))
                    && (bankMap[b].relIdx == glbDataPkg::relIdxOf(wrReq[p].addr))
                    && bankRdBusy[b]) begin
                    blocked = 1'b1;
                end
            end
            wrRdy[p] = running && !blocked;
        end
    end

endmodule

`default_nettype wire

// File: source/glbTop.sv
// Global buffer top level joining the control FSM, read and write routers and four SRAM banks
`timescale 1ns/1ns
`default_nettype none

module glbTop (
    input  wire logic                                               clk,
    input  wire logic                                               rstN,
    // Configuration
    input  wire logic                                               cfgStart,
    input  wire logic                                               cfgVld,
    input  wire glbCfgPkg::bankIdxT                                 cfgBank,
    input  wire glbCfgPkg::bankMapT                                 cfgEntry,
    input  wire logic                                               runStart,
    input  wire logic                                               runStop,
    input  wire logic                                               clearBanks,
    output logic                                                    running,
    output logic                                                    bankFinish,
    output logic                                                    bankClr,
    // Write ports
    input  wire logic [glbCfgPkg::numWrPort-1:0]                    wrVld,
    input  wire glbDataPkg::wrReqT [glbCfgPkg::numWrPort-1:0]       wrReq,
    output logic [glbCfgPkg::numWrPort-1:0]                         wrRdy,
    // Read ports
    input  wire logic [glbCfgPkg::numRdPort-1:0]                    rdReqVld,
    input  wire glbDataPkg::portAddrT [glbCfgPkg::numRdPort-1:0]    rdReqAddr,
    output logic [glbCfgPkg::numRdPort-1:0]                         rdReqRdy,
    output logic [glbCfgPkg::numRdPort-1:0]                         rdDatVld,
    output glbDataPkg::wordT [glbCfgPkg::numRdPort-1:0]             rdDat,
    input  wire logic [glbCfgPkg::numRdPort-1:0]                    rdDatRdy
);

    glbCfgPkg::bankMapArrT                          bankMap;
    glbDataPkg::bankCmdT [glbCfgPkg::numBank-1:0]   bankRdCmd;
    logic [glbCfgPkg::numBank-1:0]                  bankRdBusy;
    glbDataPkg::bankCmdT [glbCfgPkg::numBank-1:0]   bankCmd;
    glbDataPkg::wordT [glbCfgPkg::numBank-1:0]      bankRdData;

    // ====================
    // Control
    // ====================

    glbBankCtrl u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .cfgStart   (cfgStart),
        .cfgVld     (cfgVld),
        .cfgBank    (cfgBank),
        .cfgEntry   (cfgEntry),
        .runStart   (runStart),
        .runStop    (runStop),
        .clearBanks (clearBanks),
        .running    (running),
        .bankFinish (bankFinish),
        .bankClr    (bankClr),
        .bankMap    (bankMap)
    );

    // ====================
    // Routing
    // ====================

    glbRdRoute u_rdRoute (
        .clk        (clk),
        .rstN       (rstN),
        .running    (running),
        .bankMap    (bankMap),
        .rdReqVld   (rdReqVld),
        .rdReqAddr  (rdReqAddr),
        .rdDatRdy   (rdDatRdy),
        .bankRdData (bankRdData),
        .rdReqRdy   (rdReqRdy),
        .rdDatVld   (rdDatVld),
        .rdDat      (rdDat),
        .bankRdCmd  (bankRdCmd),
        .bankRdBusy (bankRdBusy)
    );

    glbWrRoute u_wrRoute (
        .running    (running),
        .bankMap    (bankMap),
        .wrVld      (wrVld),
        .wrReq      (wrReq),
        .bankRdCmd  (bankRdCmd),
        .bankRdBusy (bankRdBusy),
        .wrRdy      (wrRdy),
        .bankCmd    (bankCmd)
    );

    // Banks
    for (genvar b = 0; b < glbCfgPkg::numBank; b++) begin : genBank
        glbBankRam u_bank (
            .clk    (clk),
            .rstN   (rstN),
            .cmd    (bankCmd[b]),
            .rdData (bankRdData[b])
        );
    end

endmodule

`default_nettype wire

// File: sim/glbTb.sv
// Global buffer testbench driving random port traffic checked against a bank memory model
`timescale 1ns/1ns
`default_nettype none

module glbTb;

    // ====================
    // Run lengths
    // ====================

    localparam int clkPeriod = 8;
    localparam int fillLen = 128;
    localparam int phaseLen = 200;
    localparam int mixLen = 600;
    localparam int rerunLen = 300;
    // Config, drain and stop cycles
    localparam int marginLen = 400;
    localparam int watchdogNs =
        (2 + fillLen + 2 * phaseLen + mixLen + rerunLen + marginLen) * clkPeriod;

    logic                                               clk;
    logic                                               rstN;
    logic                                               cfgStart;
    logic                                               cfgVld;
    glbCfgPkg::bankIdxT                                 cfgBank;
    glbCfgPkg::bankMapT                                 cfgEntry;
    logic                                               runStart;
    logic                                               runStop;
    logic                                               clearBanks;
    logic                                               running;
    logic                                               bankFinish;
    logic                                               bankClr;
    logic [glbCfgPkg::numWrPort-1:0]                    wrVld;
    glbDataPkg::wrReqT [glbCfgPkg::numWrPort-1:0]       wrReq;
    logic [glbCfgPkg::numWrPort-1:0]                    wrRdy;
    logic [glbCfgPkg::numRdPort-1:0]                    rdReqVld;
    glbDataPkg::portAddrT [glbCfgPkg::numRdPort-1:0]    rdReqAddr;
    logic [glbCfgPkg::numRdPort-1:0]                    rdReqRdy;
    logic [glbCfgPkg::numRdPort-1:0]                    rdDatVld;
    glbDataPkg::wordT [glbCfgPkg::numRdPort-1:0]        rdDat;
    logic [glbCfgPkg::numRdPort-1:0]                    rdDatRdy;

    // Model state
    logic [63:0]                                        lcgState;
    glbDataPkg::wordT model [glbCfgPkg::numBank][glbDataPkg::bankDepth];
    glbCfgPkg::bankMapArrT                              tbMap;
    glbCfgPkg::bankMapArrT                              map1;
    glbCfgPkg::bankMapArrT                              map2;
    // Words in flight per read port with the oldest first
    glbDataPkg::wordT retQ [glbCfgPkg::numRdPort][$];
    logic                                               expRun;
    logic                                               expFinish;
    logic                                               expClr;
    logic [glbCfgPkg::numRdPort-1:0]                    holdVld;
    glbDataPkg::wordT [glbCfgPkg::numRdPort-1:0]        holdDat;
    logic [glbCfgPkg::numWrPort-1:0]                    lastWrRdy;

    glbTop dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .cfgStart   (cfgStart),
        .cfgVld     (cfgVld),
        .cfgBank    (cfgBank),
        .cfgEntry   (cfgEntry),
        .runStart   (runStart),
        .runStop    (runStop),
        .clearBanks (clearBanks),
        .running    (running),
        .bankFinish (bankFinish),
        .bankClr    (bankClr),
        .wrVld      (wrVld),
        .wrReq      (wrReq),
        .wrRdy      (wrRdy),
        .rdReqVld   (rdReqVld),
        .rdReqAddr  (rdReqAddr),
        .rdReqRdy   (rdReqRdy),
        .rdDatVld   (rdDatVld),
        .rdDat      (rdDat),
        .rdDatRdy   (rdDatRdy)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // ====================
    // Helpers
    // ====================

    // 64-bit LCG with the upper half as the random word
    function automatic logic [31:0] randWord();
        lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcgState[63:32];
    endfunction

    function automatic glbCfgPkg::bankMapT mapEntry(int wrP, int rdP, int rel);
        glbCfgPkg::bankMapT e;
        e.used = 1'b1;
        e.wrPort = glbCfgPkg::wrPortIdxT'(wrP);
        e.rdPort = glbCfgPkg::rdPortIdxT'(rdP);
        e.relIdx = glbCfgPkg::bankIdxT'(rel);
        return e;
    endfunction

    // Physical bank behind a port address or -1 if unmapped
    function automatic int bankOf(logic isRd, int port, glbDataPkg::portAddrT addr);
        int hit;
        logic portMatch;
        hit = -1;
        for (int b = 0; b < glbCfgPkg::numBank; b++) begin
            portMatch = isRd ? (int'(tbMap[b].rdPort) == port)
                             : (int'(tbMap[b].wrPort) == port);
            if (tbMap[b].used && portMatch && (tbMap[b].relIdx == addr[7:6])) begin
                hit = b;
            end
        end
        return hit;
    endfunction

    // Fill pattern unique per port and port address
    function automatic glbDataPkg::wordT fillWord(int port, int idx);
        return 32'h5A5A_0000 | (32'(port) << 12) | 32'(idx);
    endfunction

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s expected %h actual %h", name, expVal, actVal);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ====================
    // Monitor and model
    // ====================

    // Runs between edges and sees what the next edge will take
    task automatic observeCycle();
        logic [glbCfgPkg::numRdPort-1:0] rdAcc;
        int rb [glbCfgPkg::numRdPort];
        int wb;
        logic blocked;
        glbDataPkg::wordT expDat;
        checkVal("running", 32'(expRun), 32'(running));
        checkVal("bankFinish", 32'(expFinish), 32'(bankFinish));
        checkVal("bankClr", 32'(expClr), 32'(bankClr));
        lastWrRdy = wrRdy;
        for (int p = 0; p < glbCfgPkg::numRdPort; p++) begin
            rdAcc[p] = rdReqVld[p] && rdReqRdy[p];
            rb[p] = bankOf(1'b1, p, rdReqAddr[p]);
            // Return register full exactly while a word is owed
            checkVal("rdDatVld", 32'(retQ[p].size() > 0), 32'(rdDatVld[p]));
            checkVal("rdReqRdy", 32'(expRun && (retQ[p].size() == 0 || rdDatRdy[p])),
                     32'(rdReqRdy[p]));
            if (holdVld[p]) begin
                checkVal("rdDatHold", holdDat[p], rdDat[p]);
            end
            holdVld[p] = rdDatVld[p] && !rdDatRdy[p];
            holdDat[p] = rdDat[p];
            if (rdDatVld[p] && rdDatRdy[p]) begin
                expDat = retQ[p].pop_front();
                checkVal("rdDat", expDat, rdDat[p]);
            end
        end
        // Reads first since a same-bank write cannot land this cycle
        for (int p = 0; p < glbCfgPkg::numRdPort; p++) begin
            if (rdAcc[p]) begin
                retQ[p].push_back(rb[p] >= 0 ? model[rb[p]][rdReqAddr[p][5:0]] : '0);
            end
        end
        for (int p = 0; p < glbCfgPkg::numWrPort; p++) begin
            wb = bankOf(1'b0, p, wrReq[p].addr);
            blocked = (wb >= 0) && ((rdAcc[0] && rb[0] == wb) || (rdAcc[1] && rb[1] == wb));
            checkVal("wrRdy", 32'(expRun && !blocked), 32'(wrRdy[p]));
            // Unmapped writes are dropped
            if (wrVld[p] && wrRdy[p] && wb >= 0) begin
                model[wb][wrReq[p].addr[5:0]] = wrReq[p].data;
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        observeCycle();
        @(posedge clk);
        #1;
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic loadMap(input glbCfgPkg::bankMapArrT m);
        tbMap = m;
        cfgStart = 1'b1;
        stepCycle();
        cfgStart = 1'b0;
        for (int b = 0; b < glbCfgPkg::numBank; b++) begin
            cfgVld = 1'b1;
            cfgBank = glbCfgPkg::bankIdxT'(b);
            cfgEntry = m[b];
            stepCycle();
        end
        cfgVld = 1'b0;
        runStart = 1'b1;
        stepCycle();
        runStart = 1'b0;
        expRun = 1'b1;
    endtask

    // Every mapped word of map1 gets a known value
    task automatic fillBanks();
        for (int i = 0; i < fillLen; i++) begin
            for (int p = 0; p < glbCfgPkg::numWrPort; p++) begin
                wrVld[p] = 1'b1;
                wrReq[p].addr = glbDataPkg::portAddrT'(i);
                wrReq[p].data = fillWord(p, i);
            end
            stepCycle();
        end
        wrVld = '0;
    endtask

    // Full address range so half the traffic hits unmapped banks
    task automatic randomTraffic(input int cycles, input logic doWr, input logic doRd,
                                 input logic [4:0] rdyTh);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            for (int p = 0; p < 2; p++) begin
                r = randWord();
                wrVld[p] = doWr && r[0];
                wrReq[p].addr = r[15:8];
                wrReq[p].data = randWord();
                rdReqVld[p] = doRd && r[1];
                rdReqAddr[p] = r[23:16];
                rdDatRdy[p] = ({1'b0, r[31:28]} < rdyTh);
            end
            stepCycle();
        end
    endtask

    task automatic drainReads();
        wrVld = '0;
        rdReqVld = '0;
        rdDatRdy = '1;
        while ((retQ[0].size() + retQ[1].size()) != 0) begin
            stepCycle();
        end
        stepCycle();
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        cfgStart = 1'b0;
        cfgVld = 1'b0;
        cfgBank = '0;
        cfgEntry = '0;
        runStart = 1'b0;
        runStop = 1'b0;
        clearBanks = 1'b0;
        wrVld = '0;
        wrReq = '0;
        rdReqVld = '0;
        rdReqAddr = '0;
        rdDatRdy = '0;
        lcgState = 64'd48486;
        tbMap = '0;
        expRun = 1'b0;
        expFinish = 1'b0;
        expClr = 1'b0;
        holdVld = '0;
        holdDat = '0;
        lastWrRdy = '0;
        // Wr 0 and rd 1 own banks 0 and 2 and the other pair banks 1 and 3
        map1[0] = mapEntry(0, 1, 0);
        map1[1] = mapEntry(1, 0, 0);
        map1[2] = mapEntry(0, 1, 1);
        map1[3] = mapEntry(1, 0, 1);
        map2[0] = mapEntry(0, 0, 0);
        map2[1] = mapEntry(0, 0, 1);
        map2[2] = mapEntry(1, 1, 0);
        map2[3] = mapEntry(1, 1, 1);
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        // Quiet outputs out of reset
        @(negedge clk);
        checkVal("rstRunning", 32'd0, 32'(running));
        checkVal("rstWrRdy", 32'd0, 32'(wrRdy));
        checkVal("rstRdReqRdy", 32'd0, 32'(rdReqRdy));
        checkVal("rstRdDatVld", 32'd0, 32'(rdDatVld));
        checkVal("rstFinish", 32'd0, 32'(bankFinish));
        checkVal("rstClr", 32'd0, 32'(bankClr));
        @(posedge clk);
        #1;
        loadMap(map1);
        fillBanks();
        // Read and write on bank 0 together
        wrVld[0] = 1'b1;
        wrReq[0].addr = 8'h05;
        wrReq[0].data = 32'hDEAD_BEEF;
        rdReqVld[1] = 1'b1;
        rdReqAddr[1] = 8'h05;
        rdDatRdy = '1;
        stepCycle();
        checkVal("clashWrRdy", 32'd0, 32'(lastWrRdy[0]));
        // Returned word is the fill value and not the clashing write
        checkVal("clashOldWord", fillWord(0, 5), rdDat[1]);
        drainReads();
        // Writes only, then reads only
        randomTraffic(phaseLen, 1'b1, 1'b0, 5'd16);
        drainReads();
        randomTraffic(phaseLen, 1'b0, 1'b1, 5'd16);
        drainReads();
        // Both directions with back-pressure
        randomTraffic(mixLen, 1'b1, 1'b1, 5'd10);
        drainReads();
        runStop = 1'b1;
        stepCycle();
        runStop = 1'b0;
        expRun = 1'b0;
        expFinish = 1'b1;
        stepCycle();
        expFinish = 1'b0;
        stepCycle();
        clearBanks = 1'b1;
        stepCycle();
        clearBanks = 1'b0;
        tbMap = '0;
        expClr = 1'b1;
        stepCycle();
        expClr = 1'b0;
        stepCycle();
        // Bank contents survive under new ownership
        loadMap(map2);
        randomTraffic(rerunLen, 1'b1, 1'b1, 5'd12);
        drainReads();
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: sim.f
source/glbCfgPkg.sv
source/glbDataPkg.sv
source/glbBankRam.sv
source/glbBankCtrl.sv
source/glbRdRoute.sv
source/glbWrRoute.sv
source/glbTop.sv
sim/glbTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the global buffer testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module glbTb -o glbTbSim > sim.log 2>&1 \
    && ./obj_dir/glbTbSim >> sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
